// File: hw/edge2en.sv
`timescale 1ns/1ns
`default_nettype none

module edge2en (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic data_i,
    output logic pos_edge_o,
    output logic neg_edge_o,
    output logic any_edge_o
);

    logic [1:0] sync_q;
    logic       prev_q;

    // two flops bring the line into the clock domain, then the last
    // synchronised value is compared with the one before it.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q     <= 2'b11;  // an idle line is high, so no edge at release.
            prev_q     <= 1'b1;
            pos_edge_o <= 1'b0;
            neg_edge_o <= 1'b0;
            any_edge_o <= 1'b0;
        end else begin
            sync_q     <= {sync_q[0], data_i};
            prev_q     <= sync_q[1];
            pos_edge_o <= sync_q[1] & ~prev_q;
            neg_edge_o <= ~sync_q[1] & prev_q;
            any_edge_o <= sync_q[1] ^ prev_q;
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_core.sv
`timescale 1ns/1ns
`default_nettype none

module uart_core (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [uart_pkg::BAUD_DIV_W-1:0] baud_div_i,
    input  logic                            rx_i,
    output logic [uart_pkg::DATA_BITS-1:0]  rx_data_o,
    output logic                            rx_valid_o,
    input  logic                            rx_ready_i,
    input  logic [uart_pkg::DATA_BITS-1:0]  tx_data_i,
    input  logic                            tx_valid_i,
    output logic                            tx_ready_o,
    output logic                            tx_o
);

    // both directions run from the same divisor.
    uart_rx u_rx (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .baud_div_i  (baud_div_i),
        .out_data_o  (rx_data_o),
        .out_valid_o (rx_valid_o),
        .out_ready_i (rx_ready_i),
        .rx_i        (rx_i)
    );

    uart_tx u_tx (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .baud_div_i (baud_div_i),
        .in_data_i  (tx_data_i),
        .in_valid_i (tx_valid_i),
        .in_ready_o (tx_ready_o),
        .tx_o       (tx_o)
    );

endmodule

`default_nettype wire

// File: hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

    localparam int DATA_BITS  = 8;  // data bits in one frame.
    localparam int BIT_IDX_W  = 3;  // wide enough to index DATA_BITS.
    localparam int BAUD_DIV_W = 32;

    // the position inside a frame, shared by the receiver and the transmitter.
    // in the receiver ST_STOP also covers holding a byte that is not yet taken.
    typedef enum logic [1:0] {
        ST_IDLE  = 2'h0,
        ST_START = 2'h1,
        ST_DATA  = 2'h2,
        ST_STOP  = 2'h3
    } uart_state_t;

endpackage

`default_nettype wire

// File: hw/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [uart_pkg::BAUD_DIV_W-1:0] baud_div_i,
    output logic [uart_pkg::DATA_BITS-1:0]  out_data_o,
    output logic                            out_valid_o,
    input  logic                            out_ready_i,
    input  logic                            rx_i
);

    import uart_pkg::*;

    uart_state_t           state;
    logic                  tick;
    logic [BAUD_DIV_W-1:0] baud_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    logic [DATA_BITS-1:0]  shift_q;
    logic                  rx_fall;
    logic                  last_bit;

    assign out_data_o = shift_q;
    assign last_bit   = tick && (bit_idx == BIT_IDX_W'(DATA_BITS - 1));

    // only the falling edge matters, as it marks the start of a frame.
    edge2en u_edge (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .data_i     (rx_i),
        .pos_edge_o (),
        .neg_edge_o (rx_fall),
        .any_edge_o ()
    );

    // one bit period is baud_div_i + 2 cycles, counting the tick cycle.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tick     <= 1'b0;
            baud_cnt <= '0;
        end else begin
            tick <= (state != ST_IDLE) && (baud_cnt == baud_div_i);
            if (state == ST_IDLE) begin
                // starting halfway puts every later tick near mid-bit.
                baud_cnt <= rx_fall ? (baud_div_i >> 1) : '0;
            end else if (tick) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= ST_IDLE;
            bit_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rx_fall) state <= ST_START;
                end
                ST_START: begin
                    if (tick) begin
                        state   <= ST_DATA;
                        bit_idx <= '0;
                    end
                end
                ST_DATA: begin
                    if (tick) bit_idx <= bit_idx + 1'b1;
                    if (last_bit) state <= ST_STOP;
                end
                ST_STOP: begin
                    if (out_ready_i) state <= ST_IDLE;  // the byte has been taken.
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if ((state == ST_DATA) && last_bit) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    // Bits come in LSB first and move down from the top.
    always_ff @(posedge clk_i) begin
        if ((state == ST_DATA) && tick) begin
            shift_q <= {rx_i, shift_q[DATA_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [uart_pkg::BAUD_DIV_W-1:0] baud_div_i,
    input  logic [uart_pkg::DATA_BITS-1:0]  in_data_i,
    input  logic                            in_valid_i,
    output logic                            in_ready_o,
    output logic                            tx_o
);

    import uart_pkg::*;

    uart_state_t           state;
    logic                  tick;
    logic [BAUD_DIV_W-1:0] baud_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    logic [DATA_BITS-1:0]  shift_q;
    logic                  take;

    assign in_ready_o = (state == ST_IDLE);
    assign take       = in_valid_i && in_ready_o;

    // the counter rests at zero in idle, so the start bit gets a full period.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tick     <= 1'b0;
            baud_cnt <= '0;
        end else begin
            tick <= (state != ST_IDLE) && (baud_cnt == baud_div_i);
            if ((state == ST_IDLE) || tick) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= ST_IDLE;
            bit_idx <= '0;
            tx_o    <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state <= ST_START;
                        tx_o  <= 1'b0;  // start bit.
                    end
                end
                ST_START: begin
                    if (tick) begin
                        state   <= ST_DATA;
                        bit_idx <= '0;
                        tx_o    <= shift_q[0];
                    end
                end
                ST_DATA: begin
                    if (tick) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == BIT_IDX_W'(DATA_BITS - 1)) begin
                            state <= ST_STOP;
                            tx_o  <= 1'b1;  // stop bit.
                        end else begin
                            tx_o <= shift_q[0];
                        end
                    end
                end
                ST_STOP: begin
                    if (tick) state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                    tx_o  <= 1'b1;
                end
            endcase
        end
    end

    // the next bit to send always sits in bit 0.
    always_ff @(posedge clk_i) begin
        if (take) begin
            shift_q <= in_data_i;
        end else if (tick && ((state == ST_START) || (state == ST_DATA))) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the UART testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

top=tb_uart_core
build_dir=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$top" --Mdir "$build_dir" \
    -f uart_core.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$("./$build_dir/V$top")
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run passes only if the testbench printed its pass line.
if printf '%s\n' "$output" | grep -qx "Test OK"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1

// File: tests/tb_uart_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart_core;

    import uart_pkg::*;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [BAUD_DIV_W-1:0] baud_div;
    logic                  ser_line;
    logic                  loop_sel;  // high routes tx_o back into rx_i.
    logic                  rx_line;
    logic [DATA_BITS-1:0]  rx_data;
    logic                  rx_valid;
    logic                  rx_ready;
    logic [DATA_BITS-1:0]  tx_data;
    logic                  tx_valid;
    logic                  tx_ready;
    logic                  tx_line;

    logic [DATA_BITS-1:0] rx_q[$];  // bytes taken from the receive stream.
    int                   bit_cycles;
    int                   errors;
    int                   tests_run;
    int                   tests_failed;

    always #20 clk = ~clk;

    assign rx_line = loop_sel ? tx_line : ser_line;

    uart_core u_dut (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .baud_div_i (baud_div),
        .rx_i       (rx_line),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid),
        .rx_ready_i (rx_ready),
        .tx_data_i  (tx_data),
        .tx_valid_i (tx_valid),
        .tx_ready_o (tx_ready),
        .tx_o       (tx_line)
    );

    // a byte leaves the receiver on an edge where valid and ready are both high.
    always @(posedge clk) begin
        if (rx_valid && rx_ready) begin
            rx_q.push_back(rx_data);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("[pass] %s", name);
        end else begin
            tests_failed++;
            $display("[fail] %s, %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic set_divisor(input int div);
        baud_div   = BAUD_DIV_W'(div);
        bit_cycles = div + 2;  // one bit period is the divisor plus two cycles.
    endtask

    // Starts on a falling edge and holds each bit of the frame for one period.
    task automatic drive_frame(input logic [DATA_BITS-1:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            ser_line = frame[i];
            repeat (bit_cycles) @(negedge clk);
        end
    endtask

    task automatic wait_rx_bytes(input int count, input string what);
        int cycles;
        cycles = 0;
        while ((rx_q.size() < count) && (cycles < 12 * bit_cycles)) begin
            @(negedge clk);
            cycles++;
        end
        if (rx_q.size() < count) begin
            stop_on_timeout({what, ": no byte arrived on the receive stream"});
        end
    endtask

    task automatic wait_tx_ready(input string what);
        int cycles;
        cycles = 0;
        while ((tx_ready !== 1'b1) && (cycles < 12 * bit_cycles)) begin
            @(negedge clk);
            cycles++;
        end
        if (tx_ready !== 1'b1) begin
            stop_on_timeout({what, ": the transmitter never became ready"});
        end
    endtask

    task automatic offer_tx_byte(input logic [DATA_BITS-1:0] data, input string what);
        wait_tx_ready(what);
        tx_data  = data;
        tx_valid = 1'b1;
        @(negedge clk);  // the transfer happens on the rising edge in between.
        tx_valid = 1'b0;
        check_value({what, " ready after transfer"}, 32'd0, 32'(tx_ready));
    endtask

    task automatic capture_tx_frame(output logic [9:0] bits, input string what);
        int cycles;
        cycles = 0;
        while ((tx_line !== 1'b0) && (cycles < 4 * bit_cycles)) begin
            @(negedge clk);
            cycles++;
        end
        if (tx_line !== 1'b0) begin
            stop_on_timeout({what, ": no start bit appeared on tx_o"});
        end
        repeat (bit_cycles / 2) @(negedge clk);  // middle of the start bit.
        for (int i = 0; i < 10; i++) begin
            bits[i] = tx_line;
            check_value({what, " ready during frame"}, 32'd0, 32'(tx_ready));
            if (i < 9) begin
                repeat (bit_cycles) @(negedge clk);
            end
        end
    endtask

    task automatic reset_test(input string name);
        int errors_before;
        errors_before = errors;
        check_value({name, " rx_valid_o"}, 32'd0, 32'(rx_valid));
        check_value({name, " tx_ready_o"}, 32'd1, 32'(tx_ready));
        check_value({name, " tx_o"}, 32'd1, 32'(tx_line));
        close_test(name, errors_before);
    endtask

    task automatic receive_test(input string name, input int count);
        logic [DATA_BITS-1:0] data;
        int                   errors_before;
        errors_before = errors;
        rx_q.delete();
        rx_ready = 1'b1;
        for (int k = 0; k < count; k++) begin
            data = DATA_BITS'($urandom);
            drive_frame(data);
            wait_rx_bytes(k + 1, name);
            check_value({name, " data"}, 32'(data), 32'(rx_q[k]));
        end
        repeat (2 * bit_cycles) @(negedge clk);
        check_value({name, " transfers"}, 32'(count), 32'(rx_q.size()));
        close_test(name, errors_before);
    endtask

    task automatic backpressure_test(input string name);
        logic [DATA_BITS-1:0] first;
        logic [DATA_BITS-1:0] second;
        int                   hold;
        int                   errors_before;
        errors_before = errors;
        rx_q.delete();
        first    = DATA_BITS'($urandom);
        second   = DATA_BITS'($urandom);
        hold     = 5 + int'($urandom % 36);
        rx_ready = 1'b0;
        drive_frame(first);  // valid is up before the stop bit ends.
        for (int c = 0; c < hold; c++) begin
            check_value({name, " valid held"}, 32'd1, 32'(rx_valid));
            check_value({name, " data held"}, 32'(first), 32'(rx_data));
            @(negedge clk);
        end
        rx_ready = 1'b1;
        wait_rx_bytes(1, name);
        check_value({name, " valid released"}, 32'd0, 32'(rx_valid));
        drive_frame(second);
        wait_rx_bytes(2, name);
        repeat (2 * bit_cycles) @(negedge clk);
        check_value({name, " transfers"}, 32'd2, 32'(rx_q.size()));
        check_value({name, " first byte"}, 32'(first), 32'(rx_q[0]));
        check_value({name, " second byte"}, 32'(second), 32'(rx_q[1]));
        close_test(name, errors_before);
    endtask

    task automatic transmit_test(input string name, input int count);
        logic [DATA_BITS-1:0] data;
        logic [9:0]           bits;
        int                   errors_before;
        errors_before = errors;
        for (int k = 0; k < count; k++) begin
            data = DATA_BITS'($urandom);
            fork
                capture_tx_frame(bits, name);
                offer_tx_byte(data, name);
            join
            check_value({name, " start bit"}, 32'd0, 32'(bits[0]));
            check_value({name, " data"}, 32'(data), 32'(bits[8:1]));
            check_value({name, " stop bit"}, 32'd1, 32'(bits[9]));
            wait_tx_ready(name);
        end
        close_test(name, errors_before);
    endtask

    task automatic loopback_test(input string name, input int count);
        logic [DATA_BITS-1:0] sent[$];
        logic [DATA_BITS-1:0] data;
        int                   errors_before;
        errors_before = errors;
        rx_q.delete();
        rx_ready = 1'b1;
        loop_sel = 1'b1;
        for (int k = 0; k < count; k++) begin
            data = DATA_BITS'($urandom);
            sent.push_back(data);
            offer_tx_byte(data, name);
        end
        wait_rx_bytes(count, name);
        repeat (2 * bit_cycles) @(negedge clk);  // lets the last stop bit finish.
        check_value({name, " transfers"}, 32'(count), 32'(rx_q.size()));
        for (int k = 0; k < count; k++) begin
            check_value({name, " data"}, 32'(sent[k]), 32'(rx_q[k]));
        end
        loop_sel = 1'b0;
        close_test(name, errors_before);
    endtask

    initial begin
        void'($urandom(4));
        rst_n    = 1'b0;
        ser_line = 1'b1;
        loop_sel = 1'b0;
        rx_ready = 1'b0;
        tx_data  = '0;
        tx_valid = 1'b0;
        set_divisor(22);
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_test("reset_state");
        // start detection adds about five cycles to the half-bit count, so a divisor
        // of 22 still puts every receive sample well inside its bit.
        receive_test("receive", 16);
        backpressure_test("rx_backpressure");
        transmit_test("transmit", 16);
        loopback_test("loopback", 8);
        set_divisor(13);
        receive_test("receive_div13", 4);
        transmit_test("transmit_div13", 4);
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_core.f
hw/uart_pkg.sv
hw/edge2en.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_core.sv
tests/tb_uart_core.sv
